/* files.f */
hw/cache_pkg.sv
hw/axi_pkg.sv
hw/dcache_store.sv
hw/line_buffer.sv
hw/axi_burst_port.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
sim/tb_axi_mem.sv
sim/tb_dcache.sv

/* hw/axi_burst_port.sv */
// axi_burst_port: AR, R, AW, W and B channel driver for line bursts and single beats
`timescale 1ns/10ps
module axi_burst_port #(
    parameter int  INDEX_BITS  = cache_pkg::INDEX_BITS_DEF,
    parameter int  OFFSET_BITS = cache_pkg::OFFSET_BITS_DEF,
    localparam int LINE_LSB    = OFFSET_BITS + cache_pkg::BYTE_BITS,
    localparam int TAG_BITS    = 32 - INDEX_BITS - LINE_LSB,
    localparam int WORDS       = 2**OFFSET_BITS,
    localparam int LEN_BITS    = axi_pkg::AXI_LEN_BITS
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  rd_start,
    input  logic                  wr_start,
    input  logic                  uncached,
    input  cache_pkg::addr_t      addr,
    input  axi_pkg::size_t        size,
    input  cache_pkg::strb_t      wstrb,
    input  cache_pkg::word_t      wdata,
    input  logic [TAG_BITS-1:0]   victim_tag,
    input  cache_pkg::word_t      victim_line [WORDS],
    output logic                  rd_done,
    output logic                  wr_done,
    output logic                  beat_valid,
    output cache_pkg::word_t      beat_data,
    output cache_pkg::addr_t      araddr,
    output logic [LEN_BITS-1:0]   arlen,
    output axi_pkg::size_t        arsize,
    output logic                  arvalid,
    input  logic                  arready,
    input  cache_pkg::word_t      rdata_m,
    input  logic                  rlast,
    input  logic                  rvalid,
    output cache_pkg::addr_t      awaddr,
    output logic [LEN_BITS-1:0]   awlen,
    output axi_pkg::size_t        awsize,
    output logic                  awvalid,
    input  logic                  awready,
    output cache_pkg::word_t      wdata_m,
    output cache_pkg::strb_t      wstrb_m,
    output logic                  wlast,
    output logic                  wvalid,
    input  logic                  wready,
    input  logic                  bvalid
);
    logic [LEN_BITS-1:0] w_cnt;
    logic                unc_wr_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            w_cnt   <= '0;
        end else begin
            if (rd_start)
                arvalid <= 1'b1;
            else if (arvalid && arready)
                arvalid <= 1'b0;

            if (wr_start) begin
                awvalid <= 1'b1;
                w_cnt   <= '0;
            end else if (awvalid && awready) begin
                awvalid <= 1'b0;
                wvalid  <= 1'b1;   // data follows the accepted address
            end

            if (wvalid && wready) begin
                w_cnt <= w_cnt + 1'b1;
                if (wlast)
                    wvalid <= 1'b0;
            end
        end
    end

    // request payload, held until the handshake
    always_ff @(posedge clk) begin
        if (rd_start) begin
            araddr <= uncached ? addr : {addr[31:LINE_LSB], {LINE_LSB{1'b0}}};
            arlen  <= uncached ? '0 : axi_pkg::BURST_LEN_LINE;
            arsize <= uncached ? size : axi_pkg::SIZE_WORD;
        end
        if (wr_start) begin
            awaddr   <= uncached ? addr
                                 : {victim_tag, addr[LINE_LSB +: INDEX_BITS], {LINE_LSB{1'b0}}};
            awlen    <= uncached ? '0 : axi_pkg::BURST_LEN_LINE;
            awsize   <= uncached ? size : axi_pkg::SIZE_WORD;
            unc_wr_q <= uncached;
        end
    end

    assign wdata_m = unc_wr_q ? wdata : victim_line[w_cnt[OFFSET_BITS-1:0]];
    assign wstrb_m = unc_wr_q ? wstrb : 4'hf;
    assign wlast   = (w_cnt == awlen);

    // R and B are always accepted
    assign beat_valid = rvalid;
    assign beat_data  = rdata_m;
    assign rd_done    = rvalid && rlast;
    assign wr_done    = bvalid;

endmodule

/* hw/axi_pkg.sv */
// memory bus burst length width, line burst length and transfer size encodings
package axi_pkg;

    localparam int AXI_LEN_BITS = 4;

    localparam logic [AXI_LEN_BITS-1:0] BURST_LEN_LINE = 4'd15; // beats minus one

    typedef logic [2:0] size_t;

    localparam size_t SIZE_WORD = 3'd2; // 4 bytes per beat

endpackage

/* hw/cache_pkg.sv */
// cache data types, geometry defaults, address field widths and controller states
package cache_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    localparam int INDEX_BITS_DEF  = 6;   // 64 lines
    localparam int OFFSET_BITS_DEF = 4;   // 16 words per line
    localparam int BYTE_BITS       = 2;   // byte within a word

    typedef enum logic [3:0] {
        idle,
        hit_write,
        wb_addr,       // victim write-back
        wb_data,
        wb_resp,
        fill_addr,     // line refill
        fill_data,
        fill_done,
        unc_rd,
        unc_rd_done,
        unc_wr,
        unc_wr_resp
    } ctrl_state_t;

endpackage

/* hw/dcache_ctrl.sv */
// dcache_ctrl: hit detection, miss sequencing FSM, stall and read data select
`timescale 1ns/10ps
module dcache_ctrl #(
    parameter int  INDEX_BITS  = cache_pkg::INDEX_BITS_DEF,
    parameter int  OFFSET_BITS = cache_pkg::OFFSET_BITS_DEF,
    localparam int LINE_LSB    = OFFSET_BITS + cache_pkg::BYTE_BITS,
    localparam int TAG_BITS    = 32 - INDEX_BITS - LINE_LSB,
    localparam int WORDS       = 2**OFFSET_BITS
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  req,
    input  logic                  we,
    input  logic                  cached,
    input  cache_pkg::addr_t      addr,
    input  logic [TAG_BITS-1:0]   tag_out,
    input  logic                  valid_out,
    input  logic                  dirty_out,
    input  cache_pkg::word_t      store_line [WORDS],
    input  cache_pkg::word_t      buffer_line [WORDS],
    input  cache_pkg::word_t      beat_data,
    input  logic                  rd_done,
    input  logic                  wr_done,
    output logic [INDEX_BITS-1:0] index,
    output logic [TAG_BITS-1:0]   fill_tag,
    output logic                  line_we,
    output logic                  line_valid,
    output logic                  line_dirty,
    output logic                  load_merge,
    output logic                  fill_start,
    output logic                  rd_start,
    output logic                  wr_start,
    output cache_pkg::word_t      rdata,
    output logic                  stall
);
    cache_pkg::ctrl_state_t state;
    cache_pkg::ctrl_state_t state_nxt;
    cache_pkg::word_t       unc_data;
    logic [OFFSET_BITS-1:0] offset;
    logic                   hit;
    logic                   idle_req;

    assign index    = addr[LINE_LSB +: INDEX_BITS];
    assign fill_tag = addr[31 -: TAG_BITS];
    assign offset   = addr[cache_pkg::BYTE_BITS +: OFFSET_BITS];
    assign hit      = valid_out && (tag_out == fill_tag);
    assign idle_req = (state == cache_pkg::idle) && req;

    always_ff @(posedge clk) begin
        if (!resetn)
            state <= cache_pkg::idle;
        else
            state <= state_nxt;
    end

    always_ff @(posedge clk) begin
        if (state == cache_pkg::unc_rd && rd_done)
            unc_data <= beat_data;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            cache_pkg::idle: begin
                if (req && !cached)
                    state_nxt = we ? cache_pkg::unc_wr : cache_pkg::unc_rd;
                else if (req && !hit)
                    state_nxt = (valid_out && dirty_out) ? cache_pkg::wb_addr
                                                         : cache_pkg::fill_addr;
                else if (req && we)
                    state_nxt = cache_pkg::hit_write;
            end
            cache_pkg::wb_addr:   state_nxt = cache_pkg::wb_data;
            cache_pkg::wb_data:   if (wr_done) state_nxt = cache_pkg::wb_resp;
            cache_pkg::wb_resp:   state_nxt = cache_pkg::fill_addr;   // victim now in memory
            cache_pkg::fill_addr: state_nxt = cache_pkg::fill_data;
            cache_pkg::fill_data: if (rd_done) state_nxt = cache_pkg::fill_done;
            cache_pkg::unc_rd:    if (rd_done) state_nxt = cache_pkg::unc_rd_done;
            cache_pkg::unc_wr:    if (wr_done) state_nxt = cache_pkg::unc_wr_resp;
            default:              state_nxt = cache_pkg::idle;
        endcase
    end

    // single-cycle strobes
    assign load_merge = idle_req && cached && hit && we;
    assign rd_start   = (idle_req && !cached && !we) || (state == cache_pkg::fill_addr);
    assign wr_start   = (idle_req && !cached && we) || (state == cache_pkg::wb_addr);
    assign fill_start = (state == cache_pkg::fill_addr);

    // buffer goes back to the store after a merge or a refill
    assign line_we    = (state == cache_pkg::hit_write) || (state == cache_pkg::fill_done);
    assign line_valid = line_we;
    assign line_dirty = we;

    always_comb begin
        case (state)
            cache_pkg::idle:        stall = req && !(cached && hit && !we);
            cache_pkg::hit_write,
            cache_pkg::fill_done,
            cache_pkg::unc_rd_done,
            cache_pkg::unc_wr_resp: stall = 1'b0;
            default:                stall = 1'b1;
        endcase
    end

    always_comb begin
        case (state)
            cache_pkg::fill_done:   rdata = buffer_line[offset];
            cache_pkg::unc_rd_done: rdata = unc_data;
            default:                rdata = store_line[offset];
        endcase
    end

endmodule

/* hw/dcache_store.sv */
// dcache_store: tag, valid, dirty and line data arrays, async read, whole-line write
`timescale 1ns/10ps
module dcache_store #(
    parameter int  INDEX_BITS  = cache_pkg::INDEX_BITS_DEF,
    parameter int  OFFSET_BITS = cache_pkg::OFFSET_BITS_DEF,
    localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS - cache_pkg::BYTE_BITS,
    localparam int WORDS       = 2**OFFSET_BITS,
    localparam int LINES       = 2**INDEX_BITS
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [INDEX_BITS-1:0] index,
    input  logic [TAG_BITS-1:0]   fill_tag,
    input  logic                  line_we,
    input  logic                  line_valid,
    input  logic                  line_dirty,
    input  cache_pkg::word_t      line_in [WORDS],
    output logic [TAG_BITS-1:0]   tag_out,
    output logic                  valid_out,
    output logic                  dirty_out,
    output cache_pkg::word_t      line_out [WORDS]
);
    logic [LINES-1:0]    valid_mem;
    logic [LINES-1:0]    dirty_mem;
    logic [TAG_BITS-1:0] tag_mem  [LINES];
    cache_pkg::word_t    data_mem [LINES][WORDS];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_mem <= '0;
            dirty_mem <= '0;
        end else if (line_we) begin
            valid_mem[index] <= line_valid;
            dirty_mem[index] <= line_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (line_we) begin
            tag_mem[index]  <= fill_tag;
            data_mem[index] <= line_in;
        end
    end

    // combinational read of the addressed entry
    assign tag_out   = tag_mem[index];
    assign valid_out = valid_mem[index];
    assign dirty_out = dirty_mem[index];
    assign line_out  = data_mem[index];

endmodule

/* hw/dcache_top.sv */
// dcache_top: data cache top level with store, line buffer, burst port and controller
`timescale 1ns/10ps
module dcache_top #(
    parameter int  INDEX_BITS  = cache_pkg::INDEX_BITS_DEF,
    parameter int  OFFSET_BITS = cache_pkg::OFFSET_BITS_DEF,
    localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS - cache_pkg::BYTE_BITS,
    localparam int WORDS       = 2**OFFSET_BITS
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             req,
    input  logic                             we,
    input  cache_pkg::addr_t                 addr,
    input  cache_pkg::strb_t                 wstrb,
    input  cache_pkg::word_t                 wdata,
    input  axi_pkg::size_t                   size,
    input  logic                             cached,
    output cache_pkg::word_t                 rdata,
    output logic                             stall,
    output cache_pkg::addr_t                 araddr,
    output logic [axi_pkg::AXI_LEN_BITS-1:0] arlen,
    output axi_pkg::size_t                   arsize,
    output logic                             arvalid,
    input  logic                             arready,
    input  cache_pkg::word_t                 rdata_m,
    input  logic                             rlast,
    input  logic                             rvalid,
    output cache_pkg::addr_t                 awaddr,
    output logic [axi_pkg::AXI_LEN_BITS-1:0] awlen,
    output axi_pkg::size_t                   awsize,
    output logic                             awvalid,
    input  logic                             awready,
    output cache_pkg::word_t                 wdata_m,
    output cache_pkg::strb_t                 wstrb_m,
    output logic                             wlast,
    output logic                             wvalid,
    input  logic                             wready,
    input  logic                             bvalid
);
    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   fill_tag;
    logic [TAG_BITS-1:0]   tag_out;
    logic                  line_we, line_valid, line_dirty;
    logic                  valid_out, dirty_out;
    logic                  load_merge, fill_start, rd_start, wr_start;
    logic                  rd_done, wr_done, beat_valid;
    cache_pkg::word_t      beat_data;
    cache_pkg::word_t      store_line  [WORDS];
    cache_pkg::word_t      buffer_line [WORDS];

    dcache_store #(.INDEX_BITS(INDEX_BITS), .OFFSET_BITS(OFFSET_BITS)) i_store (
        .clk, .resetn, .index, .fill_tag, .line_we, .line_valid, .line_dirty,
        .line_in(buffer_line), .tag_out, .valid_out, .dirty_out, .line_out(store_line)
    );

    line_buffer #(.OFFSET_BITS(OFFSET_BITS)) i_line_buffer (
        .clk, .resetn, .load_merge, .fill_start, .beat_valid, .beat_data,
        .store_line, .offset(addr[cache_pkg::BYTE_BITS +: OFFSET_BITS]),
        .we, .wstrb, .wdata, .line(buffer_line)
    );

    axi_burst_port #(.INDEX_BITS(INDEX_BITS), .OFFSET_BITS(OFFSET_BITS)) i_burst_port (
        .clk, .resetn, .rd_start, .wr_start, .uncached(!cached), .addr, .size, .wstrb,
        .wdata, .victim_tag(tag_out), .victim_line(store_line), .rd_done, .wr_done,
        .beat_valid, .beat_data, .araddr, .arlen, .arsize, .arvalid, .arready,
        .rdata_m, .rlast, .rvalid, .awaddr, .awlen, .awsize, .awvalid, .awready,
        .wdata_m, .wstrb_m, .wlast, .wvalid, .wready, .bvalid
    );

    dcache_ctrl #(.INDEX_BITS(INDEX_BITS), .OFFSET_BITS(OFFSET_BITS)) i_ctrl (
        .clk, .resetn, .req, .we, .cached, .addr, .tag_out, .valid_out, .dirty_out,
        .store_line, .buffer_line, .beat_data, .rd_done, .wr_done, .index, .fill_tag,
        .line_we, .line_valid, .line_dirty, .load_merge, .fill_start, .rd_start,
        .wr_start, .rdata, .stall
    );

endmodule

/* hw/line_buffer.sv */
// line_buffer: one-line staging register, store byte merge and refill beat capture
`timescale 1ns/10ps
module line_buffer #(
    parameter int  OFFSET_BITS = cache_pkg::OFFSET_BITS_DEF,
    localparam int WORDS       = 2**OFFSET_BITS
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   load_merge,
    input  logic                   fill_start,
    input  logic                   beat_valid,
    input  cache_pkg::word_t       beat_data,
    input  cache_pkg::word_t       store_line [WORDS],
    input  logic [OFFSET_BITS-1:0] offset,
    input  logic                   we,
    input  cache_pkg::strb_t       wstrb,
    input  cache_pkg::word_t       wdata,
    output cache_pkg::word_t       line [WORDS]
);
    logic [OFFSET_BITS-1:0] beat_cnt;

    function automatic cache_pkg::word_t merge(cache_pkg::word_t old_word,
                                               cache_pkg::strb_t strb,
                                               cache_pkg::word_t new_word);
        cache_pkg::word_t res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                res[8*b +: 8] = new_word[8*b +: 8];
        end
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn)
            beat_cnt <= '0;
        else if (fill_start)
            beat_cnt <= '0;
        else if (beat_valid)
            beat_cnt <= beat_cnt + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (load_merge) begin
            for (int i = 0; i < WORDS; i++) begin
                if (i == int'(offset))
                    line[i] <= merge(store_line[i], wstrb, wdata);
                else
                    line[i] <= store_line[i];
            end
        end else if (beat_valid) begin
            // write miss: the store lands on its own beat
            if (we && beat_cnt == offset)
                line[beat_cnt] <= merge(beat_data, wstrb, wdata);
            else
                line[beat_cnt] <= beat_data;
        end
    end

endmodule

/* sim/tb_axi_mem.sv */
// tb_axi_mem: memory slave model with a word array, bursts, and aw/w ready stalls
`timescale 1ns/10ps
module tb_axi_mem #(
    parameter int          WORDS_LOG2 = 12,
    parameter logic [31:0] INIT_XOR   = 32'h5a3c_0000
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  cache_pkg::addr_t                 araddr,
    input  logic [axi_pkg::AXI_LEN_BITS-1:0] arlen,
    input  logic                             arvalid,
    output logic                             arready,
    output cache_pkg::word_t                 rdata_m,
    output logic                             rlast,
    output logic                             rvalid,
    input  cache_pkg::addr_t                 awaddr,
    input  logic                             awvalid,
    output logic                             awready,
    input  cache_pkg::word_t                 wdata_m,
    input  cache_pkg::strb_t                 wstrb_m,
    input  logic                             wlast,
    input  logic                             wvalid,
    output logic                             wready,
    output logic                             bvalid
);
    cache_pkg::word_t                 mem [2**WORDS_LOG2];
    logic [WORDS_LOG2-1:0]            r_ptr;
    logic [WORDS_LOG2-1:0]            w_ptr;
    logic [axi_pkg::AXI_LEN_BITS-1:0] r_left;
    logic                             r_busy;
    logic [1:0]                       phase;

    // word address xor a constant
    initial begin
        for (int i = 0; i < 2**WORDS_LOG2; i++)
            mem[i] = i ^ INIT_XOR;
    end

    assign arready = !r_busy;
    assign rvalid  = r_busy;           // R never stalls
    assign rlast   = r_busy && (r_left == 0);
    assign rdata_m = mem[r_ptr];

    // write side backs off every third cycle
    assign awready = resetn && (phase != 2'd2);
    assign wready  = resetn && (phase != 2'd2);

    always @(posedge clk) begin
        if (!resetn) begin
            r_busy <= 1'b0;
            bvalid <= 1'b0;
            phase  <= 2'd0;
        end else begin
            phase  <= (phase == 2'd2) ? 2'd0 : phase + 1'b1;
            bvalid <= wvalid && wready && wlast;   // one-cycle response
            if (arvalid && arready) begin
                r_busy <= 1'b1;
                r_ptr  <= araddr[WORDS_LOG2+1:2];
                r_left <= arlen;
            end else if (r_busy) begin
                r_busy <= (r_left != 0);
                r_ptr  <= r_ptr + 1'b1;
                r_left <= r_left - 1'b1;
            end
            if (awvalid && awready)
                w_ptr <= awaddr[WORDS_LOG2+1:2];
            if (wvalid && wready) begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb_m[b])
                        mem[w_ptr][8*b +: 8] <= wdata_m[8*b +: 8];
                end
                w_ptr <= w_ptr + 1'b1;
            end
        end
    end

endmodule

/* sim/tb_dcache.sv */
// data cache testbench top with clock, reset, directed and random tests and reference model
`timescale 1ns/10ps
module tb_dcache;

    localparam int          ACCESSES    = 212;   // 12 directed, 200 random
    localparam int          CYCLE_LIMIT = 10 + ACCESSES * 80;
    localparam int          MEM_LOG2    = 12;
    localparam logic [31:0] INIT_XOR    = 32'h5a3c_0000;

    logic clk = 1'b0;
    logic resetn, req, we, cached, stall;
    logic arvalid, arready, rlast, rvalid, awvalid, awready, wlast, wvalid, wready, bvalid;
    cache_pkg::addr_t addr, araddr, awaddr;
    cache_pkg::word_t wdata, rdata, rdata_m, wdata_m, expected;
    cache_pkg::strb_t wstrb, wstrb_m, last_wstrb;
    axi_pkg::size_t   size, arsize, awsize, last_arsize, last_awsize;
    logic [axi_pkg::AXI_LEN_BITS-1:0] arlen, awlen, last_arlen, last_awlen;
    cache_pkg::word_t shadow [2**MEM_LOG2];
    string test_name;
    int    errors = 0, test_errors = 0, tests = 0, reads = 0, cycles = 0, stall_cycles;
    int    ar_cnt = 0, w_bursts = 0, w_beat = 0, burst_beats = 0;
    logic [31:0] lcg_state;

    dcache_top i_dut (.*);
    tb_axi_mem #(.WORDS_LOG2(MEM_LOG2), .INIT_XOR(INIT_XOR)) i_mem (.*);

    always #20 clk = ~clk;

    function automatic cache_pkg::addr_t word_addr(int tag, int index, int offset);
        return (tag << 12) | (index << 6) | (offset << 2);
    endfunction

    // memory as the processor sees it with writes merged byte by byte
    function automatic cache_pkg::word_t ref_model(cache_pkg::addr_t a, logic w,
                                                   cache_pkg::strb_t s, cache_pkg::word_t d);
        logic [MEM_LOG2-1:0] i;
        i = a[MEM_LOG2+1:2];
        for (int b = 0; b < 4; b++) begin
            if (w && s[b])
                shadow[i][8*b +: 8] = d[8*b +: 8];
        end
        return shadow[i];
    endfunction

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_count(string what, int exp, int act);
        assert (exp == act) else begin
            $display("error %s %s: expected %0d actual %0d", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic start_test(string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == test_errors)
            $display("%s: ok", test_name);
        else
            $display("%s: %0d errors", test_name, errors - test_errors);
    endtask

    // one request held until stall drops
    task automatic access(logic w, logic c, cache_pkg::addr_t a, cache_pkg::strb_t s,
                          cache_pkg::word_t d);
        @(posedge clk);
        #2;
        req    = 1'b1;
        we     = w;
        cached = c;
        addr   = a;
        wstrb  = s;
        wdata  = d;
        stall_cycles = 0;
        @(negedge clk);
        while (stall) begin
            stall_cycles++;
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        req = 1'b0;
    endtask

    // completed requests checked mid-cycle
    always @(negedge clk) begin
        if (resetn && req && !stall) begin
            if (we) begin
                void'(ref_model(addr, 1'b1, wstrb, wdata));
            end else begin
                expected = ref_model(addr, 1'b0, 4'h0, 32'h0);
                reads++;
                assert (rdata === expected) else begin
                    $display("error %s: expected %h actual %h", test_name, expected, rdata);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (resetn) begin
            if (arvalid && arready) begin
                ar_cnt++;
                last_arlen  = arlen;
                last_arsize = arsize;
            end
            if (awvalid && awready) begin
                last_awlen  = awlen;
                last_awsize = awsize;
            end
            if (wvalid && wready) begin
                w_beat++;
                last_wstrb = wstrb_m;
                if (wlast) begin
                    burst_beats = w_beat;
                    w_bursts++;
                    w_beat = 0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the DUT stalled past %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        cache_pkg::addr_t a;
        logic [31:0] r;
        logic c;
        int ar0, wb0;
        resetn = 1'b0;
        req    = 1'b0;
        we     = 1'b0;
        cached = 1'b1;
        addr   = '0;
        wstrb  = '0;
        wdata  = '0;
        size   = axi_pkg::SIZE_WORD;
        for (int i = 0; i < 2**MEM_LOG2; i++)
            shadow[i] = i ^ INIT_XOR;
        lcg_state = 32'd19;
        repeat (10) @(posedge clk);
        #2 resetn = 1'b1;
        @(negedge clk);
        assert (!stall && !arvalid && !awvalid && !wvalid) else begin
            $display("stall or a bus valid is high after reset");
            errors++;
        end

        start_test("cold_miss");
        ar0 = ar_cnt;
        access(1'b0, 1'b1, word_addr(0, 3, 5), 4'h0, 32'h0);
        check_count("read bursts", 1, ar_cnt - ar0);
        check_count("arlen", 15, last_arlen);
        check_count("arsize", axi_pkg::SIZE_WORD, last_arsize);
        end_test();

        start_test("line_hits");
        ar0 = ar_cnt;
        for (int o = 0; o < 16; o += 7) begin
            access(1'b0, 1'b1, word_addr(0, 3, o), 4'h0, 32'h0);
            check_count("stall cycles", 0, stall_cycles);
        end
        check_count("read bursts", 0, ar_cnt - ar0);
        end_test();

        start_test("write_hit");
        access(1'b1, 1'b1, word_addr(0, 3, 9), 4'b0110, 32'hdead_beef);
        check_count("stall cycles", 1, stall_cycles);
        access(1'b0, 1'b1, word_addr(0, 3, 9), 4'h0, 32'h0);
        end_test();

        start_test("dirty_evict");
        ar0 = ar_cnt;
        wb0 = w_bursts;
        access(1'b0, 1'b1, word_addr(1, 3, 2), 4'h0, 32'h0);
        check_count("write bursts", 1, w_bursts - wb0);
        check_count("awlen", 15, last_awlen);
        check_count("awsize", axi_pkg::SIZE_WORD, last_awsize);
        check_count("beats to wlast", 16, burst_beats);
        check_count("read bursts", 1, ar_cnt - ar0);
        a = word_addr(0, 3, 9);
        expected = ref_model(a, 1'b0, 4'h0, 32'h0);
        assert (i_mem.mem[a[MEM_LOG2+1:2]] === expected) else begin
            $display("error %s memory: expected %h actual %h", test_name, expected,
                     i_mem.mem[a[MEM_LOG2+1:2]]);
            errors++;
        end
        access(1'b0, 1'b1, a, 4'h0, 32'h0);   // clean victim so refill only
        end_test();

        start_test("uncached");
        access(1'b1, 1'b0, word_addr(3, 3, 4), 4'b1001, 32'h1234_5678);
        check_count("awlen", 0, last_awlen);
        check_count("awsize", axi_pkg::SIZE_WORD, last_awsize);
        check_count("wstrb", 4'b1001, last_wstrb);
        size = 3'd1;   // halfword
        access(1'b0, 1'b0, word_addr(3, 3, 4), 4'h0, 32'h0);
        check_count("arlen", 0, last_arlen);
        check_count("arsize", 1, last_arsize);
        access(1'b1, 1'b0, word_addr(3, 5, 0), 4'b0011, 32'hcafe_f00d);
        check_count("awsize", 1, last_awsize);
        check_count("wstrb", 4'b0011, last_wstrb);
        size = axi_pkg::SIZE_WORD;
        access(1'b0, 1'b0, word_addr(3, 5, 0), 4'h0, 32'h0);
        check_count("arsize", axi_pkg::SIZE_WORD, last_arsize);
        end_test();

        // tags 0 to 2 cached and tag 3 only uncached
        start_test("random");
        for (int n = 0; n < 200; n++) begin
            lcg_state = lcg_next(lcg_state);
            r = lcg_state >> 8;
            c = (r[2:0] != 3'd0);
            a = word_addr(c ? r[4:3] % 3 : 3, {r[6:5], 4'd5}, r[10:7]);
            lcg_state = lcg_next(lcg_state);
            access(r[11], c, a, r[15:12], lcg_state);
        end
        end_test();

        $display("%0d tests, %0d reads checked, %0d errors", tests, reads, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule
